//--- hdl/regex_pkg.sv
// pattern search shared definitions
package regex_pkg;

    localparam int REG_WIDTH = 32; // every host register

    ////////////////////////////////////////////////////////////
    // host commands, compared as a full register
    ////////////////////////////////////////////////////////////
    typedef enum logic [REG_WIDTH-1:0] {
        CMD_NOP          = 0,
        CMD_WRITE        = 1,
        CMD_READ         = 2,
        CMD_START        = 3,
        CMD_RESTART      = 4,
        CMD_RESET        = 5,
        CMD_READ_ELAPSED = 6
    } cmd_t;

    // controller state, zero extended on the status port
    typedef enum logic [2:0] {
        STATUS_IDLE     = 3'd0,
        STATUS_RUNNING  = 3'd1,
        STATUS_ACCEPTED = 3'd2,
        STATUS_REJECTED = 3'd3,
        STATUS_ERROR    = 3'd4
    } status_t;

    ////////////////////////////////////////////////////////////
    // descriptor layout
    ////////////////////////////////////////////////////////////
    localparam int CHAR_WIDTH       = 8;
    localparam int MAX_PATTERN_LEN  = 7;     // byte 0 is length, bytes 1..7 pattern
    localparam int DESCRIPTOR_BYTES = 8;     // one memory word ahead of the text
    localparam logic [CHAR_WIDTH-1:0] WILDCARD_CHAR = 8'h2e; // '.'

endpackage

//--- hdl/mem_port_if.sv
// engine memory read port
`timescale 1ns/1ps

interface mem_port_if #(
    parameter int ADDR_WIDTH = 9,
    parameter int DATA_WIDTH = 64
);
    logic [ADDR_WIDTH-1:0] addr;
    logic                  valid;
    logic                  ready;
    logic [DATA_WIDTH-1:0] data;   // one cycle after the request is taken

    modport engine (
        output addr, valid,
        input  ready, data
    );

    modport ctrl (
        input  addr, valid,
        output ready, data
    );

endinterface

//--- hdl/text_bram.sv
// dual width text memory
`timescale 1ns/1ps

module text_bram #(
    parameter int READ_WIDTH       = 64,
    parameter int READ_ADDR_WIDTH  = 9,
    parameter int WRITE_WIDTH      = 32,
    parameter int WRITE_ADDR_WIDTH = 10
)
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [READ_ADDR_WIDTH-1:0]  r_addr,
    input  logic                        r_valid,
    output logic [READ_WIDTH-1:0]       r_data,
    input  logic [WRITE_ADDR_WIDTH-1:0] w_addr,
    input  logic [WRITE_WIDTH-1:0]      w_data,
    input  logic                        w_valid
);

    localparam int DEPTH    = 2 ** READ_ADDR_WIDTH;
    localparam int SEL_BITS = $clog2(READ_WIDTH / WRITE_WIDTH); // half select

    logic [READ_WIDTH-1:0] mem [DEPTH];

    // narrow write into one slice of the wide word
    always_ff @(posedge clk)
    begin
        if (w_valid)
        begin
            mem[w_addr[WRITE_ADDR_WIDTH-1:SEL_BITS]][w_addr[SEL_BITS-1:0]*WRITE_WIDTH +: WRITE_WIDTH]
                <= w_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            r_data <= '0;
        end
        else if (r_valid)
        begin
            r_data <= mem[r_addr]; // registered read
        end
    end

    // host writes must land inside the word array
    assert property (@(posedge clk) disable iff (rst)
        w_valid |-> !$isunknown(w_addr) && (int'(w_addr >> SEL_BITS) < DEPTH))
        else $error("write address out of range");

endmodule

//--- hdl/match_engine.sv
// streaming pattern match engine
`timescale 1ns/1ps

module match_engine
    import regex_pkg::*;
#(
    parameter int READ_WIDTH      = 64,
    parameter int READ_ADDR_WIDTH = 9
)
(
    input  logic                 clk,
    input  logic                 rst,
    mem_port_if.engine           mem,
    input  logic [REG_WIDTH-1:0] start_pointer,
    input  logic [REG_WIDTH-1:0] end_pointer,
    input  logic                 start_valid,
    output logic                 start_ready,
    output logic                 done,
    output logic                 accept,
    output logic                 error
);

    localparam int BYTE_SEL = $clog2(READ_WIDTH / CHAR_WIDTH);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_DESC_REQ  = 3'd1;
    localparam logic [2:0] S_DESC_WAIT = 3'd2;
    localparam logic [2:0] S_TEXT_REQ  = 3'd3;
    localparam logic [2:0] S_TEXT_WAIT = 3'd4;
    localparam logic [2:0] S_SCAN      = 3'd5;

    logic [2:0]                                   state_q;
    logic [REG_WIDTH-1:0]                         sp_q, ep_q, pos_q;
    logic [2:0]                                   len_q;
    logic [2:0]                                   fill_q, fill_d;
    logic [MAX_PATTERN_LEN-1:0][CHAR_WIDTH-1:0]   pat_q;
    logic [MAX_PATTERN_LEN-1:0][CHAR_WIDTH-1:0]   win_q, win_d;
    logic [READ_WIDTH-1:0]                        word_q;
    logic [CHAR_WIDTH-1:0]                        cur_byte;
    logic [CHAR_WIDTH-1:0]                        desc_len;
    logic                                         desc_bad, text_empty, hit;
    logic                                         done_q, accept_q, error_q;

    assign start_ready = (state_q == S_IDLE);
    assign done        = done_q;
    assign accept      = accept_q;
    assign error       = error_q;

    // one request at a time, addr held until taken
    assign mem.valid = (state_q == S_DESC_REQ) || (state_q == S_TEXT_REQ);
    assign mem.addr  = (state_q == S_DESC_REQ) ? sp_q[BYTE_SEL +: READ_ADDR_WIDTH]
                                               : pos_q[BYTE_SEL +: READ_ADDR_WIDTH];

    ////////////////////////////////////////////////////////////
    // descriptor and pointer checks
    ////////////////////////////////////////////////////////////
    assign desc_len   = mem.data[CHAR_WIDTH-1:0];
    assign desc_bad   = (desc_len == '0) || (desc_len > MAX_PATTERN_LEN)
                     || (sp_q[BYTE_SEL-1:0] != '0)
                     || ({1'b0, ep_q} < {1'b0, sp_q} + DESCRIPTOR_BYTES);
    assign text_empty = (ep_q == sp_q + DESCRIPTOR_BYTES);

    ////////////////////////////////////////////////////////////
    // byte window and wildcard compare
    ////////////////////////////////////////////////////////////
    assign cur_byte = word_q[pos_q[BYTE_SEL-1:0]*CHAR_WIDTH +: CHAR_WIDTH];
    assign win_d    = {win_q[MAX_PATTERN_LEN-2:0], cur_byte}; // newest at 0
    assign fill_d   = (fill_q == 3'(MAX_PATTERN_LEN)) ? fill_q : fill_q + 3'd1;

    // last pattern char lines up with the newest byte
    always_comb
    begin
        hit = (fill_d >= len_q);
        for (int i = 0; i < MAX_PATTERN_LEN; i++)
        begin
            if (i < len_q)
            begin
                if (pat_q[i] != WILDCARD_CHAR && pat_q[i] != win_d[len_q - 1 - i])
                begin
                    hit = 1'b0;
                end
            end
        end
    end

    // control path
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q  <= S_IDLE;
            done_q   <= 1'b0;
            accept_q <= 1'b0;
            error_q  <= 1'b0;
        end
        else
        begin
            done_q   <= 1'b0; // single cycle pulses
            accept_q <= 1'b0;
            error_q  <= 1'b0;
            case (state_q)
                S_IDLE:
                begin
                    if (start_valid)
                    begin
                        state_q <= S_DESC_REQ;
                    end
                end
                S_DESC_REQ:
                begin
                    if (mem.ready)
                    begin
                        state_q <= S_DESC_WAIT;
                    end
                end
                S_DESC_WAIT:
                begin
                    if (desc_bad || text_empty)
                    begin
                        done_q  <= 1'b1;
                        error_q <= desc_bad;
                        state_q <= S_IDLE;
                    end
                    else
                    begin
                        state_q <= S_TEXT_REQ;
                    end
                end
                S_TEXT_REQ:
                begin
                    if (mem.ready)
                    begin
                        state_q <= S_TEXT_WAIT;
                    end
                end
                S_TEXT_WAIT: state_q <= S_SCAN;
                S_SCAN:
                begin
                    if (hit || (pos_q + 1 == ep_q))
                    begin
                        done_q   <= 1'b1;
                        accept_q <= hit;
                        state_q  <= S_IDLE;
                    end
                    else if (pos_q[BYTE_SEL-1:0] == '1)
                    begin
                        state_q <= S_TEXT_REQ; // word used up
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        case (state_q)
            S_IDLE:
            begin
                sp_q <= start_pointer;
                ep_q <= end_pointer;
            end
            S_DESC_WAIT:
            begin
                len_q  <= desc_len[2:0];
                pat_q  <= mem.data[CHAR_WIDTH +: MAX_PATTERN_LEN*CHAR_WIDTH];
                pos_q  <= sp_q + DESCRIPTOR_BYTES; // first text byte
                fill_q <= '0;
            end
            S_TEXT_WAIT: word_q <= mem.data;
            S_SCAN:
            begin
                win_q  <= win_d;
                fill_q <= fill_d;
                pos_q  <= pos_q + 1;
            end
            default: ;
        endcase
    end

    // a taken request must return before the next one
    assert property (@(posedge clk) disable iff (rst)
        (mem.valid && mem.ready) |=> !mem.valid)
        else $error("second request while one is in flight");

endmodule

//--- hdl/cmd_ctrl.sv
// host command controller
`timescale 1ns/1ps

module cmd_ctrl
    import regex_pkg::*;
#(
    parameter int READ_WIDTH       = 64,
    parameter int READ_ADDR_WIDTH  = 9,
    parameter int WRITE_WIDTH      = 32,
    parameter int WRITE_ADDR_WIDTH = 10
)
(
    input  logic                        clk,
    input  logic                        rst_master,
    input  logic [REG_WIDTH-1:0]        data_in,
    input  logic [REG_WIDTH-1:0]        address,
    input  logic [REG_WIDTH-1:0]        cmd,
    output logic [REG_WIDTH-1:0]        status,
    output logic [REG_WIDTH-1:0]        data_out,
    mem_port_if.ctrl                    mem,
    output logic [READ_ADDR_WIDTH-1:0]  bram_r_addr,
    output logic                        bram_r_valid,
    output logic [WRITE_ADDR_WIDTH-1:0] bram_w_addr,
    output logic [WRITE_WIDTH-1:0]      bram_w_data,
    output logic                        bram_w_valid,
    input  logic [READ_WIDTH-1:0]       bram_r_data,
    output logic                        start_valid,
    input  logic                        start_ready,
    input  logic                        done,
    input  logic                        accept,
    input  logic                        error,
    output logic                        soft_rst
);

    localparam int SEL_BITS = $clog2(READ_WIDTH / REG_WIDTH); // slice select bits

    status_t              status_q, status_d;
    logic [REG_WIDTH-1:0] elapsed_q, elapsed_d;

    assign soft_rst = rst_master || (cmd == CMD_RESET);
    assign status   = {{(REG_WIDTH-$bits(status_t)){1'b0}}, status_q};
    assign mem.data = bram_r_data; // engine sees the memory word directly

    always_ff @(posedge clk)
    begin
        if (soft_rst)
        begin
            status_q  <= STATUS_IDLE;
            elapsed_q <= '0;
        end
        else
        begin
            status_q  <= status_d;
            elapsed_q <= elapsed_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // command decode and read port ownership
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        status_d     = status_q;
        elapsed_d    = elapsed_q;
        data_out     = '0;
        bram_r_addr  = '0;
        bram_r_valid = 1'b0;
        bram_w_addr  = '0;
        bram_w_data  = '0;
        bram_w_valid = 1'b0;
        mem.ready    = 1'b0;
        start_valid  = 1'b0;

        if (status_q == STATUS_RUNNING)
        begin
            // engine owns the read port until done
            mem.ready    = 1'b1;
            bram_r_addr  = mem.addr;
            bram_r_valid = mem.valid;
            if (done)
            begin
                if (error)
                    status_d = STATUS_ERROR;
                else if (accept)
                    status_d = STATUS_ACCEPTED;
                else
                    status_d = STATUS_REJECTED;
            end
            if (!(&elapsed_q))
            begin
                elapsed_d = elapsed_q + 1; // saturate at all ones
            end
        end
        else
        begin
            case (cmd)
                CMD_WRITE:
                begin
                    bram_w_addr  = address[WRITE_ADDR_WIDTH-1:0];
                    bram_w_data  = data_in[WRITE_WIDTH-1:0];
                    bram_w_valid = 1'b1;
                end
                CMD_READ:
                begin
                    bram_r_addr  = address[SEL_BITS +: READ_ADDR_WIDTH];
                    bram_r_valid = 1'b1;
                    data_out     = bram_r_data[address[SEL_BITS-1:0]*REG_WIDTH +: REG_WIDTH];
                end
                CMD_READ_ELAPSED: data_out = elapsed_q;
                CMD_START:
                begin
                    if (status_q == STATUS_IDLE)
                    begin
                        start_valid  = 1'b1;
                        mem.ready    = 1'b1;
                        bram_r_addr  = mem.addr;
                        bram_r_valid = mem.valid;
                        elapsed_d    = '0;
                        if (start_ready)
                        begin
                            status_d = STATUS_RUNNING;
                        end
                    end
                end
                CMD_RESTART:
                begin
                    status_d = STATUS_IDLE; // finished back to idle
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    assert property (@(posedge clk) disable iff (soft_rst)
        !(bram_w_valid && mem.valid && mem.ready))
        else $error("host write and engine read granted together");

    // a run only ends through the engine's done pulse
    assert property (@(posedge clk) disable iff (rst_master)
        (status_q == STATUS_RUNNING && !done && !soft_rst) |=> status_q == STATUS_RUNNING)
        else $error("status left running without done");

endmodule

//--- hdl/regex_top.sv
// pattern search coprocessor top
`timescale 1ns/1ps

module regex_top
    import regex_pkg::*;
#(
    parameter int READ_WIDTH       = 64,
    parameter int READ_ADDR_WIDTH  = 9,
    parameter int WRITE_WIDTH      = 32,
    parameter int WRITE_ADDR_WIDTH = 10
)
(
    input  logic                 clk,
    input  logic                 rst_master,
    input  logic [REG_WIDTH-1:0] data_in,
    input  logic [REG_WIDTH-1:0] address,
    input  logic [REG_WIDTH-1:0] start_pointer,
    input  logic [REG_WIDTH-1:0] end_pointer,
    input  logic [REG_WIDTH-1:0] cmd,
    output logic [REG_WIDTH-1:0] status,
    output logic [REG_WIDTH-1:0] data_out
);

    logic [READ_ADDR_WIDTH-1:0]  bram_r_addr;
    logic                        bram_r_valid;
    logic [READ_WIDTH-1:0]       bram_r_data;
    logic [WRITE_ADDR_WIDTH-1:0] bram_w_addr;
    logic [WRITE_WIDTH-1:0]      bram_w_data;
    logic                        bram_w_valid;
    logic                        start_valid, start_ready;
    logic                        done, accept, error;
    logic                        soft_rst;

    mem_port_if #(.ADDR_WIDTH(READ_ADDR_WIDTH), .DATA_WIDTH(READ_WIDTH)) eng_mem ();

    ////////////////////////////////////////////////////////////
    // instances
    ////////////////////////////////////////////////////////////
    cmd_ctrl #(
        .READ_WIDTH       (READ_WIDTH),
        .READ_ADDR_WIDTH  (READ_ADDR_WIDTH),
        .WRITE_WIDTH      (WRITE_WIDTH),
        .WRITE_ADDR_WIDTH (WRITE_ADDR_WIDTH)
    ) u_ctrl (
        .clk          (clk),
        .rst_master   (rst_master),
        .data_in      (data_in),
        .address      (address),
        .cmd          (cmd),
        .status       (status),
        .data_out     (data_out),
        .mem          (eng_mem.ctrl),
        .bram_r_addr  (bram_r_addr),
        .bram_r_valid (bram_r_valid),
        .bram_w_addr  (bram_w_addr),
        .bram_w_data  (bram_w_data),
        .bram_w_valid (bram_w_valid),
        .bram_r_data  (bram_r_data),
        .start_valid  (start_valid),
        .start_ready  (start_ready),
        .done         (done),
        .accept       (accept),
        .error        (error),
        .soft_rst     (soft_rst)
    );

    text_bram #(
        .READ_WIDTH       (READ_WIDTH),
        .READ_ADDR_WIDTH  (READ_ADDR_WIDTH),
        .WRITE_WIDTH      (WRITE_WIDTH),
        .WRITE_ADDR_WIDTH (WRITE_ADDR_WIDTH)
    ) u_bram (
        .clk     (clk),
        .rst     (soft_rst),
        .r_addr  (bram_r_addr),
        .r_valid (bram_r_valid),
        .r_data  (bram_r_data),
        .w_addr  (bram_w_addr),
        .w_data  (bram_w_data),
        .w_valid (bram_w_valid)
    );

    match_engine #(
        .READ_WIDTH      (READ_WIDTH),
        .READ_ADDR_WIDTH (READ_ADDR_WIDTH)
    ) u_engine (
        .clk           (clk),
        .rst           (soft_rst),
        .mem           (eng_mem.engine),
        .start_pointer (start_pointer),
        .end_pointer   (end_pointer),
        .start_valid   (start_valid),
        .start_ready   (start_ready),
        .done          (done),
        .accept        (accept),
        .error         (error)
    );

endmodule

//--- dv/tb_checker.sv
// result checker for the search coprocessor
`timescale 1ns/1ps

module tb_checker
    import regex_pkg::*;
(
    input  logic                 clk,
    input  logic [REG_WIDTH-1:0] status,
    input  logic [REG_WIDTH-1:0] data_out,
    output int                   error_count
);

    localparam int K_STATUS  = 0;
    localparam int K_DATA    = 1;
    localparam int K_NONZERO = 2;

    string                cur_name;
    int                   kind;
    logic [REG_WIDTH-1:0] expected;
    logic                 pending;
    int                   checks;
    int                   tests;
    int                   failed_tests;
    int                   errs_seen; // error count at the start of the current test

    initial
    begin
        error_count  = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        errs_seen    = 0;
        pending      = 1'b0;
    end

    task automatic queue_check(input string name, input int k, input logic [REG_WIDTH-1:0] exp);
        cur_name = name;
        kind     = k;
        expected = exp;
        pending  = 1'b1; // taken at the next falling edge
    endtask

    task automatic expect_status(input string name, input logic [REG_WIDTH-1:0] exp);
        queue_check(name, K_STATUS, exp);
    endtask

    task automatic expect_data(input string name, input logic [REG_WIDTH-1:0] exp);
        queue_check(name, K_DATA, exp);
    endtask

    task automatic expect_nonzero(input string name);
        queue_check(name, K_NONZERO, '0);
    endtask

    ////////////////////////////////////////////////////////////
    // compare at the falling edge
    ////////////////////////////////////////////////////////////
    always @(negedge clk)
    begin
        logic [REG_WIDTH-1:0] actual;
        if (pending)
        begin
            pending = 1'b0;
            checks++;
            actual = (kind == K_STATUS) ? status : data_out;
            if (kind == K_NONZERO)
            begin
                if (actual == '0)
                begin
                    error_count++;
                    $display("%s: elapsed counter still zero after a finished run", cur_name);
                end
            end
            else if (actual !== expected)
            begin
                error_count++;
                $display("Mismatch %s: expected %h, actual %h", cur_name, expected, actual);
            end
        end
    end

    task automatic end_test(input string name);
        tests++;
        if (error_count != errs_seen)
            failed_tests++;
        $display("test %s: %s", name, (error_count == errs_seen) ? "ok" : "failed");
        errs_seen = error_count;
    endtask

    task automatic report();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, error_count);
    endtask

endmodule

//--- dv/tb_top.sv
// testbench for the pattern search coprocessor
`timescale 1ns/1ps

module tb_top
    import regex_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int MEM_BYTES  = 4096;
    localparam int REGION     = 128;                               // bytes per search
    localparam int MAX_TEXT   = REGION - DESCRIPTOR_BYTES;
    localparam int RUN_LIMIT  = MAX_TEXT + 3 * (MAX_TEXT / 8) + 16; // worst search cycles
    localparam int N_SEARCH   = 24;
    localparam int N_RW       = 40;
    localparam int WATCHDOG_CYCLES =
        2 * (20 + 3 * N_RW + N_SEARCH * (RUN_LIMIT + REGION / 4 + 12));

    logic                 clk;
    logic                 rst_master;
    logic [REG_WIDTH-1:0] data_in, address, start_pointer, end_pointer, cmd;
    logic [REG_WIDTH-1:0] status, data_out;
    int                   err_count;
    int                   region_idx;
    int                   run_cycles;
    logic [7:0]           model_mem [MEM_BYTES]; // byte image of the DUT memory

    regex_top DUT (
        .clk           (clk),
        .rst_master    (rst_master),
        .data_in       (data_in),
        .address       (address),
        .start_pointer (start_pointer),
        .end_pointer   (end_pointer),
        .cmd           (cmd),
        .status        (status),
        .data_out      (data_out)
    );

    tb_checker chk (
        .clk         (clk),
        .status      (status),
        .data_out    (data_out),
        .error_count (err_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [REG_WIDTH-1:0] model_word(input int w);
        return {model_mem[4*w+3], model_mem[4*w+2], model_mem[4*w+1], model_mem[4*w]};
    endfunction

    ////////////////////////////////////////////////////////////
    // reference search rule on the model memory
    ////////////////////////////////////////////////////////////
    function automatic status_t ref_status(input int sp, input int ep);
        int len;
        bit found;
        bit same;
        if ((sp % DESCRIPTOR_BYTES) != 0 || ep < sp + DESCRIPTOR_BYTES)
            return STATUS_ERROR;
        len   = model_mem[sp];
        found = 1'b0;
        if (len == 0 || len > MAX_PATTERN_LEN)
            return STATUS_ERROR;
        for (int s = sp + DESCRIPTOR_BYTES; s + len <= ep; s++)
        begin
            same = 1'b1;
            for (int k = 0; k < len; k++)
            begin
                if (model_mem[sp+1+k] != WILDCARD_CHAR && model_mem[sp+1+k] != model_mem[s+k])
                    same = 1'b0;
            end
            found |= same;
        end
        return found ? STATUS_ACCEPTED : STATUS_REJECTED;
    endfunction

    task automatic load_region(input int first, input int last);
        for (int w = first / 4; w <= last / 4; w++)
        begin
            cmd     = CMD_WRITE; // one word per cycle while held
            address = w;
            data_in = model_word(w);
            next_cycle();
        end
        cmd = CMD_NOP;
    endtask

    // random a..d text, descriptor, optional planted copy of the pattern
    task automatic build_region(input int len, input int pat_base, input int pat_span,
                                input int n_dots, input bit plant, input int end_off,
                                output int sp, output int ep);
        int          tlen;
        int          at;
        logic [55:0] pat;
        sp = region_idx * REGION;
        region_idx++;
        ep   = (end_off > 0) ? sp + end_off : sp + 24 + $urandom % (MAX_TEXT - 15);
        tlen = ep - sp - DESCRIPTOR_BYTES;
        for (int b = sp; b < sp + REGION; b++)
            model_mem[b] = 8'h61 + 8'($urandom % 4);
        pat = '0;
        for (int k = 0; k < MAX_PATTERN_LEN; k++)
        begin
            if (k < len)
                pat[8*k +: 8] = 8'(pat_base + $urandom % pat_span);
        end
        if (plant && tlen >= len)
        begin
            at = sp + DESCRIPTOR_BYTES + $urandom % (tlen - len + 1);
            for (int k = 0; k < len; k++)
                model_mem[at + k] = pat[8*k +: 8];
        end
        for (int k = 0; k < n_dots; k++)
            pat[8*($urandom % len) +: 8] = WILDCARD_CHAR;
        model_mem[sp] = 8'(len);
        for (int k = 0; k < MAX_PATTERN_LEN; k++)
            model_mem[sp + 1 + k] = pat[8*k +: 8];
        load_region(sp, sp + REGION - 1);
    endtask

    task automatic run_search(input string name, input int sp, input int ep);
        logic [REG_WIDTH-1:0] exp;
        exp           = REG_WIDTH'(ref_status(sp, ep));
        start_pointer = sp;
        end_pointer   = ep;
        cmd           = CMD_START;
        next_cycle();
        cmd        = CMD_NOP;
        run_cycles = 0;
        while (status == STATUS_RUNNING && run_cycles < RUN_LIMIT)
        begin
            run_cycles++; // matches the cycles the counter sees in running
            next_cycle();
        end
        chk.expect_status(name, exp);
        next_cycle();
        cmd = CMD_READ_ELAPSED;
        chk.expect_data(name, REG_WIDTH'(run_cycles));
        next_cycle();
        chk.expect_nonzero(name);
        next_cycle();
        cmd = CMD_RESTART;
        next_cycle();
        cmd = CMD_NOP;
        chk.expect_status(name, STATUS_IDLE);
        repeat (3) next_cycle();
        cmd = CMD_READ_ELAPSED; // count frozen after completion
        chk.expect_data(name, REG_WIDTH'(run_cycles));
        next_cycle();
        cmd = CMD_NOP;
        chk.end_test(name);
    endtask

    task automatic search_case(input string name, input int len, input int pat_base,
                               input int pat_span, input int n_dots, input bit plant,
                               input int sp_shift, input int end_off);
        int sp;
        int ep;
        build_region(len, pat_base, pat_span, n_dots, plant, end_off, sp, ep);
        run_search(name, sp + sp_shift, ep);
    endtask

    task automatic write_read_test();
        int                   addrs [N_RW];
        logic [REG_WIDTH-1:0] word;
        for (int i = 0; i < N_RW; i++)
        begin
            addrs[i] = $urandom % 1024;
            word     = $urandom;
            for (int k = 0; k < 4; k++)
                model_mem[4*addrs[i] + k] = word[8*k +: 8];
            cmd     = CMD_WRITE;
            address = addrs[i];
            data_in = word;
            next_cycle();
        end
        for (int i = 0; i < N_RW; i++)
        begin
            cmd     = CMD_READ;
            address = addrs[i];
            next_cycle();
            chk.expect_data("write_read", model_word(addrs[i])); // second cycle held
            next_cycle();
        end
        cmd = CMD_NOP;
        chk.end_test("write_read");
    endtask

    task automatic reset_mid_run();
        int sp;
        int ep;
        build_region(7, 8'h71, 10, 0, 1'b0, REGION, sp, ep); // long text, no match
        start_pointer = sp;
        end_pointer   = ep;
        cmd           = CMD_START;
        next_cycle();
        cmd = CMD_NOP;
        repeat (4) next_cycle();
        chk.expect_status("reset_mid_run", STATUS_RUNNING);
        cmd = CMD_RESET;
        next_cycle();
        cmd = CMD_NOP;
        chk.expect_status("reset_mid_run", STATUS_IDLE);
        next_cycle();
        cmd = CMD_READ_ELAPSED;
        chk.expect_data("reset_mid_run", '0);
        next_cycle();
        cmd = CMD_NOP;
        chk.end_test("reset_mid_run");
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        void'($urandom(95));
        rst_master    = 1'b1;
        cmd           = CMD_NOP;
        data_in       = '0;
        address       = '0;
        start_pointer = '0;
        end_pointer   = '0;
        region_idx    = 0;
        repeat (10) @(posedge clk);
        #2;
        rst_master = 1'b0;

        chk.expect_status("after_reset", STATUS_IDLE);
        next_cycle();
        cmd = CMD_READ_ELAPSED;
        chk.expect_data("after_reset", '0);
        next_cycle();
        cmd = CMD_NOP;
        chk.end_test("after_reset");

        write_read_test();
        for (int len = 1; len <= MAX_PATTERN_LEN; len++)
            search_case($sformatf("literal_len%0d", len), len, 8'h61, 26, 0, 1'b1, 0, 0);
        for (int len = 1; len <= MAX_PATTERN_LEN; len++)
            search_case($sformatf("absent_len%0d", len), len, 8'h71, 10, 0, 1'b0, 0, 0);
        for (int i = 0; i < 4; i++)
            search_case($sformatf("wildcard_%0d", i), 3 + i, 8'h61, 4, 1 + i % 2,
                        (i % 2) == 0, 0, 0);
        search_case("error_len0", 0, 8'h61, 4, 0, 1'b0, 0, 0);
        search_case("error_len8", 8, 8'h61, 4, 0, 1'b0, 0, 0);
        search_case("error_unaligned", 3, 8'h61, 4, 0, 1'b1, 4, 0);
        search_case("error_short_end", 3, 8'h61, 4, 0, 1'b0, 0, 4);
        search_case("empty_text", 3, 8'h61, 4, 0, 1'b0, 0, DESCRIPTOR_BYTES);
        reset_mid_run();

        chk.report();
        if (err_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- all.f
hdl/regex_pkg.sv
hdl/mem_port_if.sv
hdl/text_bram.sv
hdl/match_engine.sv
hdl/cmd_ctrl.sv
hdl/regex_top.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f all.f -o tb_sim \
    || { echo "compile failed"; exit 1; }
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && echo "simulation ok" || { echo "simulation bad"; exit 1; }
